//--- project.f
+incdir+include
logic/rv_isa_pkg.sv
logic/lsu_pkg.sv
logic/mem_bus_if.sv
logic/mem_op_decode.sv
logic/load_store_unit.sv
logic/data_ram.sv
logic/lsu_subsystem.sv
dv/lsu_asserts.sv
dv/lsu_tb.sv

//--- dv/lsu_tb.sv
// Testbench for the memory stage, random loads and stores checked against a byte-array model.
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_tb
    import rv_isa_pkg::*;
();

    localparam int  LAT       = `LSU_RAM_LATENCY;
    localparam int  RAM_BYTES = 2**`LSU_RAM_AW;
    localparam int  ROUNDS    = 16;
    localparam int  N_INSTR   = RAM_BYTES / 4 + ROUNDS * 12 + 16;  // clear sweep, rounds, rest.
    localparam real WATCHDOG_NS = N_INSTR * (LAT + 6) * 20.0 + 5000.0;

    logic       clk = 1'b0;
    logic       rst_n;
    xlen_t      pc;
    xlen_t      inst;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    logic       busy;
    logic       wb_pending;
    logic       wb_en;
    reg_idx_t   wb_rd;
    xlen_t      wb_data;

    logic [7:0]  model [RAM_BYTES];      // expected RAM contents, one entry per byte.
    logic [31:0] rng    = 32'hdecc224f;
    xlen_t       cur_pc = '0;
    int          pass_cnt;
    int          fail_cnt;
    int          test_fail;
    int          pulses;                 // wb_en pulses seen during the last instruction.
    int          span;                   // cycles busy was high during the last instruction.
    int          pend_span;              // cycles wb_pending was high during the last instruction.
    reg_idx_t    seen_rd;
    xlen_t       seen_data;

    lsu_subsystem lsu_subsystem_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc         (pc),
        .inst       (inst),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .busy       (busy),
        .wb_pending (wb_pending),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    always #10 clk = ~clk;

    // ########################################
    // stimulus helpers and reference model
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic imm12_t rand_imm();
        return imm12_t'(rand32());
    endfunction

    function automatic xlen_t rand_addr(input logic [1:0] lg);
        return rand32() & ~((32'd1 << lg) - 32'd1);   // aligned to 1 << lg bytes.
    endfunction

    function automatic xlen_t sext12(input imm12_t imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic xlen_t enc_load(input logic [2:0] f3, input reg_idx_t rd, input imm12_t imm);
        return {imm, 5'd1, f3, rd, 7'b0000011};
    endfunction

    function automatic xlen_t enc_store(input logic [2:0] f3, input imm12_t imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic void model_store(input logic [2:0] f3, input xlen_t ea, input xlen_t data);
        logic [`LSU_RAM_AW-1:0] a;
        a = ea[`LSU_RAM_AW-1:0];              // the RAM wraps modulo its size.
        for (int i = 0; i < (1 << f3[1:0]); i++) begin
            model[a + i[`LSU_RAM_AW-1:0]] = data[8*i +: 8];
        end
    endfunction

    function automatic xlen_t model_load(input logic [2:0] f3, input xlen_t ea);
        logic [`LSU_RAM_AW-1:0] a;
        logic [31:0]            w;
        a = ea[`LSU_RAM_AW-1:0];
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = model[a + i[`LSU_RAM_AW-1:0]];
        end
        case (f3)
            3'b000:  return {{24{w[7]}}, w[7:0]};
            3'b100:  return {24'h0, w[7:0]};
            3'b001:  return {{16{w[15]}}, w[15:0]};
            3'b101:  return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    // ########################################
    // checking and instruction issue
    task automatic compare(input string name, input xlen_t got, input xlen_t exp);
        if (got === exp) begin
            pass_cnt++;
        end else begin
            $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
            fail_cnt++;
            test_fail++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s at pc 0x%08h", what, cur_pc);
        fail_cnt++;
        test_fail++;
    endtask

    task automatic end_test(input string name);
        $display("test %-22s %s, %0d failed checks", name,
                 (test_fail == 0) ? "done" : "FAILED", test_fail);
        test_fail = 0;
    endtask

    // follows an access until busy falls, or watches a fixed window when none should start.
    task automatic issue(input xlen_t word, input xlen_t a, input xlen_t b,
                         input bit new_pc, input bit expect_run);
        int cycles;
        bit seen;
        cycles    = 0;
        seen      = 1'b0;
        pulses    = 0;
        span      = 0;
        pend_span = 0;
        @(posedge clk);
        if (new_pc) cur_pc = cur_pc + 32'd4;
        pc       <= cur_pc;
        inst     <= word;
        rs1_data <= a;
        rs2_data <= b;
        do begin
            @(negedge clk);
            cycles++;
            if (busy) begin
                seen = 1'b1;
                span++;
            end
            if (wb_pending) pend_span++;
            if (wb_en) begin
                pulses++;
                seen_rd   = wb_rd;
                seen_data = wb_data;
            end
        end while (expect_run ? (!(seen && !busy) && cycles < LAT + 8) : (cycles < LAT + 4));
        if (expect_run && !seen) report_failure("no access started");
        else if (expect_run && busy) report_failure("busy never fell");
        else if (expect_run) compare("busy_cycles", span, LAT + 2);
        else if (seen || pulses != 0 || pend_span != 0)
            report_failure("ignored instruction started an access");
    endtask

    task automatic do_store(input logic [2:0] f3, input xlen_t ea, input imm12_t imm,
                            input xlen_t data);
        issue(enc_store(f3, imm), ea - sext12(imm), data, 1'b1, 1'b1);
        if (pulses != 0) report_failure("store produced a write-back pulse");
        compare("wb_pending_cycles", pend_span, 0);
        model_store(f3, ea, data);
    endtask

    task automatic do_load(input logic [2:0] f3, input xlen_t ea, input imm12_t imm);
        reg_idx_t rd;
        rd = reg_idx_t'(rand32());
        issue(enc_load(f3, rd, imm), ea - sext12(imm), rand32(), 1'b1, 1'b1);
        compare("wb_pending_cycles", pend_span, LAT + 2);
        if (pulses == 0) begin
            report_failure("load produced no write-back pulse");
        end else if (pulses > 1) begin
            report_failure("load produced more than one write-back pulse");
        end else begin
            compare("wb_rd", seen_rd, rd);
            compare("wb_data", seen_data, model_load(f3, ea));
        end
    endtask

    // ########################################
    // test sequence
    initial begin
        xlen_t      ea;
        xlen_t      alias_ea;
        xlen_t      w;
        logic [2:0] f3;
        logic [2:0] lf3;
        logic [6:0] other_ops [4];
        rst_n     = 1'b0;
        pc        = '0;
        inst      = enc_load(3'b010, 5'd1, 12'h000);  // valid load, held on the reset pc.
        rs1_data  = '0;
        rs2_data  = '0;
        other_ops = '{7'b0110011, 7'b0010011, 7'b0110111, 7'b1100011};
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        repeat (8) begin
            @(negedge clk);
            compare("busy", busy, 1'b0);
            compare("wb_pending", wb_pending, 1'b0);
            compare("wb_en", wb_en, 1'b0);
        end
        end_test("reset_idle");

        for (int a = 0; a < RAM_BYTES; a += 4) do_store(3'b010, a, rand_imm(), '0);
        end_test("ram_clear");

        repeat (ROUNDS) begin
            ea = rand_addr(2'd2);
            do_store(3'b010, ea, rand_imm(), rand32());
            do_load(3'b010, ea, rand_imm());
        end
        end_test("word_round_trip");

        repeat (ROUNDS) begin
            ea = rand_addr(2'd2);
            w  = rand32();
            f3 = {2'b00, w[0]};
            do_store(3'b010, ea, rand_imm(), rand32());
            do_store(f3, ea | (w[0] ? {w[2], 1'b0} : w[2:1]), rand_imm(), rand32());
            do_load(3'b010, ea, rand_imm());
        end
        end_test("sub_word_stores");

        for (int r = 0; r < ROUNDS; r++) begin
            ea = rand_addr(2'd2);
            w  = rand32();
            w  = r[0] ? (w | 32'h80808080) : (w & 32'h7f7f7f7f);  // every lane's top bit.
            do_store(3'b010, ea, rand_imm(), w);
            do_load(3'b000, ea | (rand32() & 32'd3), rand_imm());
            do_load(3'b100, ea | (rand32() & 32'd3), rand_imm());
            do_load(3'b001, ea | (rand32() & 32'd2), rand_imm());
            do_load(3'b101, ea | (rand32() & 32'd2), rand_imm());
        end
        end_test("load_extension");

        repeat (ROUNDS) begin
            w        = rand32();
            f3       = (w[1:0] == 2'd3) ? 3'b010 : {1'b0, w[1:0]};
            lf3      = (f3 != 3'b010 && w[2]) ? (f3 | 3'b100) : f3;
            ea       = rand_addr(f3[1:0]);
            alias_ea = (ea & 32'(RAM_BYTES - 1)) | (rand32() & ~32'(RAM_BYTES - 1));
            do_store(f3, ea, rand_imm() | 12'h800, rand32());       // negative offset.
            do_load(lf3, alias_ea, rand_imm() & 12'h7ff);          // positive offset.
        end
        end_test("address_arith");

        for (int i = 0; i < 4; i++) begin
            w = rand32();
            issue({w[31:7], other_ops[i]}, rand32(), rand32(), 1'b1, 1'b0);
        end
        for (int f = 3; f < 8; f++) begin
            issue(enc_store(f[2:0], rand_imm()), rand32(), rand32(), 1'b1, 1'b0);
            if (f != 4 && f != 5) begin
                issue(enc_load(f[2:0], 5'd3, rand_imm()), rand32(), rand32(), 1'b1, 1'b0);
            end
        end
        ea = rand_addr(2'd2);
        do_store(3'b010, ea, rand_imm(), rand32());
        issue(enc_load(3'b010, 5'd4, rand_imm()), rand32(), rand32(), 1'b0, 1'b0);
        do_load(3'b010, ea, rand_imm());
        end_test("ignored_instructions");

        $display("checks passed %0d, checks failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("Regression failed");
        $finish;
    end

endmodule

//--- dv/lsu_asserts.sv
// Protocol checks on the RAM request handshake and write-back pulse of the load/store unit.
`timescale 1ns/1ps

module lsu_asserts
    import rv_isa_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  busy,
    input logic  wb_en,
    input logic  read_en,
    input logic  write_en,
    input logic  read_ready,
    input logic  write_ready,
    input xlen_t addr
);

    // ########################################
    // request side
    no_dual_enable: assert property (@(posedge clk) disable iff (!rst_n)
        !(read_en && write_en)) else $error("read_en and write_en high together");

    read_held: assert property (@(posedge clk) disable iff (!rst_n)
        (read_en && !read_ready) |=> (read_en && $stable(addr)))
        else $error("read request dropped or moved before read_ready");

    write_held: assert property (@(posedge clk) disable iff (!rst_n)
        (write_en && !write_ready) |=> (write_en && $stable(addr)))
        else $error("write request dropped or moved before write_ready");

    busy_covers_enable: assert property (@(posedge clk) disable iff (!rst_n)
        (read_en || write_en) |-> busy) else $error("RAM enable high while not busy");

    // ########################################
    // write-back side
    wb_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |=> !wb_en) else $error("wb_en held for more than one cycle");

endmodule

bind load_store_unit lsu_asserts lsu_asserts_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .busy        (busy),
    .wb_en       (wb_en),
    .read_en     (mem.read_en),
    .write_en    (mem.write_en),
    .read_ready  (mem.read_ready),
    .write_ready (mem.write_ready),
    .addr        (mem.addr)
);

//--- logic/lsu_subsystem.sv
// Memory stage top level joining the decoder, the load/store unit and the data RAM.
`timescale 1ns/1ps

module lsu_subsystem
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  xlen_t    pc,
    input  xlen_t    inst,
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    output logic     busy,
    output logic     wb_pending,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output xlen_t    wb_data
);

    mem_op_e  op;
    reg_idx_t rd;
    imm12_t   imm;

    mem_bus_if mem_bus ();

    mem_op_decode mem_op_decode_i (
        .inst (inst),
        .op   (op),
        .rd   (rd),
        .imm  (imm)
    );

    load_store_unit load_store_unit_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc         (pc),
        .op         (op),
        .rd         (rd),
        .imm        (imm),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .busy       (busy),
        .wb_pending (wb_pending),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .mem        (mem_bus.requester)
    );

    data_ram data_ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mem_bus.responder)
    );

endmodule

//--- logic/data_ram.sv
// Byte-addressed data RAM with sized writes and a fixed-latency ready pulse.
`timescale 1ns/1ps
`include "lsu_defines.svh"

module data_ram
    import lsu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    mem_bus_if.responder bus
);

    localparam int LAT = `LSU_RAM_LATENCY;
    localparam int CW  = (LAT > 1) ? $clog2(LAT) : 1;

    logic [7:0]           mem [2**`LSU_RAM_AW];
    ram_addr_t            base;
    logic [LSU_LANES-1:0] lane_en;
    logic [CW-1:0]        cnt;
    logic                 active;     // a request is being served.
    logic                 start;
    logic                 fire;

    // ########################################
    // address and lane decode
    always_comb begin
        case (bus.size)
            SZ_BYTE: begin
                base    = bus.addr[`LSU_RAM_AW-1:0];
                lane_en = LSU_LANES'(1);
            end
            SZ_HALF: begin
                base    = {bus.addr[`LSU_RAM_AW-1:1], 1'b0};
                lane_en = LSU_LANES'(3);
            end
            default: begin
                base    = {bus.addr[`LSU_RAM_AW-1:2], 2'b00};
                lane_en = '1;
            end
        endcase
    end

    // ########################################
    // latency countdown
    assign start = !active && (bus.read_en || bus.write_en);
    assign fire  = start ? (LAT == 1) : (active && cnt == CW'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active          <= 1'b0;
            cnt             <= '0;
            bus.read_ready  <= 1'b0;
            bus.write_ready <= 1'b0;
        end else begin
            bus.read_ready  <= fire && bus.read_en;
            bus.write_ready <= fire && bus.write_en;
            if (start) begin
                active <= 1'b1;
                cnt    <= CW'(LAT - 1);
            end else if (active) begin
                if (cnt == '0) active <= 1'b0;     // the ready pulse has just been seen.
                else cnt <= cnt - 1'b1;
            end
        end
    end

    // the access itself happens on the edge that raises ready.
    always_ff @(posedge clk) begin
        if (fire) begin
            for (int i = 0; i < LSU_LANES; i++) begin
                if (bus.write_en && lane_en[i]) mem[base + ram_addr_t'(i)] <= bus.wdata[8*i +: 8];
                bus.rdata[8*i +: 8] <= lane_en[i] ? mem[base + ram_addr_t'(i)] : 8'h00;
            end
        end
    end

endmodule

//--- logic/load_store_unit.sv
// Load/store unit FSM that issues one RAM access per new pc and returns load results.
`timescale 1ns/1ps
`include "lsu_defines.svh"

module load_store_unit
    import rv_isa_pkg::*;
    import lsu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  xlen_t        pc,
    input  mem_op_e      op,
    input  reg_idx_t     rd,
    input  imm12_t       imm,
    input  xlen_t        rs1_data,
    input  xlen_t        rs2_data,
    output logic         busy,
    output logic         wb_pending,
    output logic         wb_en,
    output reg_idx_t     wb_rd,
    output xlen_t        wb_data,
    mem_bus_if.requester mem
);

    lsu_state_e   state;
    lsu_state_e   state_next;
    xlen_t        last_pc;          // pc seen on the last idle cycle.
    xlen_t        eff_addr;
    xlen_t        store_data;
    xlen_t        ld_value;
    access_size_t op_size;
    logic         op_is_load;
    logic         op_signed;
    logic         ld_signed;
    logic         accept;
    logic         read_done;

    // ########################################
    // operation attributes
    always_comb begin
        op_size    = SZ_WORD;
        op_is_load = 1'b0;
        op_signed  = 1'b0;
        store_data = rs2_data;
        case (op)
            OP_LB:   begin op_size = SZ_BYTE; op_is_load = 1'b1; op_signed = 1'b1; end
            OP_LBU:  begin op_size = SZ_BYTE; op_is_load = 1'b1; end
            OP_LH:   begin op_size = SZ_HALF; op_is_load = 1'b1; op_signed = 1'b1; end
            OP_LHU:  begin op_size = SZ_HALF; op_is_load = 1'b1; end
            OP_LW:   op_is_load = 1'b1;
            OP_SB:   begin
                op_size    = SZ_BYTE;
                store_data = {{(`LSU_XLEN-8){1'b0}}, rs2_data[7:0]};
            end
            OP_SH:   begin
                op_size    = SZ_HALF;
                store_data = {{(`LSU_XLEN-16){1'b0}}, rs2_data[15:0]};
            end
            default: op_size = SZ_WORD;
        endcase
    end

    assign eff_addr  = rs1_data + {{(`LSU_XLEN-12){imm[11]}}, imm};  // immediate is signed.
    assign accept    = (state == ST_IDLE) && (pc != last_pc) && (op != OP_NONE);
    assign read_done = (state == ST_READ) && mem.read_ready;

    // the RAM returns the addressed bytes in the low lanes.
    always_comb begin
        case (mem.size)
            SZ_BYTE: ld_value = {{(`LSU_XLEN-8){ld_signed & mem.rdata[7]}}, mem.rdata[7:0]};
            SZ_HALF: ld_value = {{(`LSU_XLEN-16){ld_signed & mem.rdata[15]}}, mem.rdata[15:0]};
            default: ld_value = mem.rdata;
        endcase
    end

    // ########################################
    // state machine
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE:  if (accept) state_next = op_is_load ? ST_READ : ST_WRITE;
            ST_READ:  if (mem.read_ready) state_next = ST_DONE;
            ST_WRITE: if (mem.write_ready) state_next = ST_DONE;
            default:  state_next = ST_IDLE;   // ST_DONE always returns to idle.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            last_pc      <= '0;
            busy         <= 1'b0;
            wb_pending   <= 1'b0;
            wb_en        <= 1'b0;
            mem.read_en  <= 1'b0;
            mem.write_en <= 1'b0;
        end else begin
            state <= state_next;
            if (state == ST_IDLE) last_pc <= pc;   // pc changes while busy are not tracked.
            if (accept) begin
                busy         <= 1'b1;
                wb_pending   <= op_is_load;
                mem.read_en  <= op_is_load;
                mem.write_en <= !op_is_load;
            end
            if (read_done) begin
                mem.read_en <= 1'b0;
                wb_en       <= 1'b1;               // one-cycle write-back pulse.
            end
            if (state == ST_WRITE && mem.write_ready) mem.write_en <= 1'b0;
            if (state == ST_DONE) begin
                busy       <= 1'b0;
                wb_pending <= 1'b0;
                wb_en      <= 1'b0;
            end
        end
    end

    // request payload is held stable for the whole access.
    always_ff @(posedge clk) begin
        if (accept) begin
            mem.addr  <= eff_addr;
            mem.wdata <= store_data;
            mem.size  <= op_size;
            ld_signed <= op_signed;
            wb_rd     <= rd;
        end
        if (read_done) wb_data <= ld_value;
    end

endmodule

//--- logic/mem_op_decode.sv
// Combinational decoder that picks out the RV32I loads and stores and assembles their immediate.
`timescale 1ns/1ps

module mem_op_decode
    import rv_isa_pkg::*;
(
    input  xlen_t    inst,
    output mem_op_e  op,
    output reg_idx_t rd,
    output imm12_t   imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];

    always_comb begin
        op  = OP_NONE;
        imm = inst[31:20];                          // I form covers the loads.
        case (opcode)
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  op = OP_LB;
                    3'b001:  op = OP_LH;
                    3'b010:  op = OP_LW;
                    3'b100:  op = OP_LBU;
                    3'b101:  op = OP_LHU;
                    default: op = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                imm = {inst[31:25], inst[11:7]};    // S form splits the immediate around rd.
                case (funct3)
                    3'b000:  op = OP_SB;
                    3'b001:  op = OP_SH;
                    3'b010:  op = OP_SW;
                    default: op = OP_NONE;
                endcase
            end
            default: begin
                op = OP_NONE;
            end
        endcase
    end

endmodule

//--- logic/mem_bus_if.sv
// Request and response bundle between the load/store unit and the data RAM.
`timescale 1ns/1ps

interface mem_bus_if import rv_isa_pkg::*, lsu_pkg::*; ();

    xlen_t        addr;         // byte address of the access.
    xlen_t        wdata;        // store data in the low lanes.
    access_size_t size;         // word, byte or half.
    logic         read_en;      // held until read_ready.
    logic         write_en;     // held until write_ready.
    xlen_t        rdata;        // valid while read_ready is high.
    logic         read_ready;
    logic         write_ready;

    modport requester (
        output addr, wdata, size, read_en, write_en,
        input  rdata, read_ready, write_ready
    );

    modport responder (
        input  addr, wdata, size, read_en, write_en,
        output rdata, read_ready, write_ready
    );

endinterface

//--- logic/lsu_pkg.sv
// Types private to the load/store unit and its data RAM.
`include "lsu_defines.svh"

package lsu_pkg;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_DONE
    } lsu_state_e;

    // ########################################
    // access size code as seen on the RAM bus
    typedef logic [1:0] access_size_t;
    localparam access_size_t SZ_WORD = 2'd0;
    localparam access_size_t SZ_BYTE = 2'd1;
    localparam access_size_t SZ_HALF = 2'd2;

    typedef logic [`LSU_RAM_AW-1:0] ram_addr_t;       // byte address inside the RAM.
    localparam int LSU_LANES = `LSU_XLEN / 8;         // byte lanes per data word.

endpackage

//--- logic/rv_isa_pkg.sv
// RV32I types used by the memory stage, covering data words, register indices and memory ops.
`include "lsu_defines.svh"

package rv_isa_pkg;

    typedef logic [`LSU_XLEN-1:0] xlen_t;     // one data word or byte address.
    typedef logic [4:0]           reg_idx_t;  // integer register index.
    typedef logic [11:0]          imm12_t;    // assembled I or S immediate.

    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    typedef enum logic [3:0] {
        OP_NONE,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } mem_op_e;

endpackage

//--- include/lsu_defines.svh
// Width and timing constants shared by the load/store subsystem and its testbench.
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data word and address width in bits.
`define LSU_XLEN 32

// Byte address width of the data RAM.
// The RAM holds 2**LSU_RAM_AW bytes, and higher address bits wrap.
`define LSU_RAM_AW 10

// Cycles from the first cycle of a request to the ready pulse.
// The value must be at least 1.
`define LSU_RAM_LATENCY 2

`endif
